// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_log_ic
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: source/bank_port.sv
/* Memory bank port
   Arbitration tree over all masters feeding one synchronous single-port SRAM */
module bank_port
#(
        parameter int N_MASTERS  = 4,
        parameter int BANK_WORDS = 64
)
(
        input  logic                                 clk,
        input  logic                                 rst_n,

        // Requests from the router, strobes steered to this bank
        input  logic [N_MASTERS-1:0]                 req_i,
        input  ic_chan_pkg::ic_req_t [N_MASTERS-1:0] data_i,
        output logic [N_MASTERS-1:0]                 gnt_o,

        // Registered response, one cycle after the grant
        output logic                                 resp_valid_o,
        output ic_chan_pkg::ic_resp_t                resp_o
);

        // Heap layout, node k has children 2k and 2k+1, leaves from N_MASTERS up
        localparam int N_NODES = 2 * N_MASTERS;
        // Word index width, BANK_WORDS is a power of two
        localparam int IDX_W = $clog2(BANK_WORDS);

        logic [N_NODES-1:1]                 tree_req;
        ic_chan_pkg::ic_req_t [N_NODES-1:1] tree_data;
        logic [N_NODES-1:1]                 tree_gnt;

        // Winning access at the root
        logic                               acc_req;
        ic_chan_pkg::ic_req_t               acc;
        logic [IDX_W-1:0]                   acc_idx;

        logic [ic_chan_pkg::DATA_W-1:0]     mem [BANK_WORDS];
        ic_chan_pkg::ic_resp_t              resp_q;
        logic                               resp_valid_q;

        //////////////////////////////////////////////////
        // Arbitration tree
        //////////////////////////////////////////////////

        // Leaves are the master inputs, lower index on the lower side
        for (genvar m = 0; m < N_MASTERS; m++)
        begin : g_leaf
                assign tree_req[N_MASTERS+m]  = req_i[m];
                assign tree_data[N_MASTERS+m] = data_i[m];
                assign gnt_o[m]               = tree_gnt[N_MASTERS+m];
        end

        // Bank takes one access every cycle, so the root is always granted
        assign tree_gnt[1] = 1'b1;

        for (genvar k = 1; k < N_MASTERS; k++)
        begin : g_node
                req_arb_node u_node
                (
                        .clk     (clk),
                        .rst_n   (rst_n),
                        .req0_i  (tree_req[2*k]),
                        .data0_i (tree_data[2*k]),
                        .gnt0_o  (tree_gnt[2*k]),
                        .req1_i  (tree_req[2*k+1]),
                        .data1_i (tree_data[2*k+1]),
                        .gnt1_o  (tree_gnt[2*k+1]),
                        .req_o   (tree_req[k]),
                        .data_o  (tree_data[k]),
                        .gnt_i   (tree_gnt[k])
                );
        end

        assign acc_req = tree_req[1];
        assign acc     = tree_data[1];
        // Row modulo bank depth, upper row bits ignored
        assign acc_idx = acc.addr.fields.row[IDX_W-1:0];

        //////////////////////////////////////////////////
        // SRAM and response register
        //////////////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (acc_req)
                begin
                        // Old word is returned on writes too
                        resp_q.rdata <= mem[acc_idx];
                        resp_q.id    <= acc.id;
                        for (int b = 0; b < ic_chan_pkg::BE_W; b++)
                        begin
                                if (acc.we && acc.be[b])
                                begin
                                        mem[acc_idx][8*b +: 8] <= acc.wdata[8*b +: 8];
                                end
                        end
                end
        end

        // Valid pulse, one cycle per access
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        resp_valid_q <= 1'b0;
                end
                else
                begin
                        resp_valid_q <= acc_req;
                end
        end

        assign resp_valid_o = resp_valid_q;
        assign resp_o       = resp_q;

endmodule

// File: source/ic_addr_pkg.sv
/* Interconnect address layout
   Word address split into row, bank and byte offset for word interleaving */
package ic_addr_pkg;

        //////////////////////////////////////////////////
        // Layout constants
        //////////////////////////////////////////////////

        // Full master address width
        localparam int ADDR_W = 32;

        // Four banks, interleaved on word granularity
        localparam int N_BANKS = 4;

        // Bank select width, two bits for four banks
        localparam int BANK_W = $clog2(N_BANKS);

        // Byte offset inside a 32-bit word
        localparam int OFFS_W = 2;

        // Row index inside a bank, whatever is left above the bank field
        localparam int ROW_W = 28;

        //////////////////////////////////////////////////
        // Address views
        //////////////////////////////////////////////////

        // Field view, row on top, byte offset at the bottom
        typedef struct packed {
                logic [ROW_W-1:0]  row;
                logic [BANK_W-1:0] bank;
                logic [OFFS_W-1:0] offs;
        } ic_addr_fields_t;

        // Same word seen flat by masters or split by the router and banks
        typedef union packed {
                logic [ADDR_W-1:0] flat;
                ic_addr_fields_t   fields;
        } ic_addr_u;

endpackage

// File: source/ic_chan_pkg.sv
/* Interconnect channel types
   Request and response payloads carried from masters through banks and back */
package ic_chan_pkg;

        //////////////////////////////////////////////////
        // Channel widths
        //////////////////////////////////////////////////

        // Data word width
        localparam int DATA_W = 32;

        // One enable per data byte
        localparam int BE_W = DATA_W / 8;

        // Master identifier, up to 256 masters
        localparam int ID_W = 8;

        //////////////////////////////////////////////////
        // Payloads
        //////////////////////////////////////////////////

        // Request as held by a master until granted
        typedef struct packed {
                ic_addr_pkg::ic_addr_u addr;
                logic                  we;
                logic [BE_W-1:0]       be;
                logic [DATA_W-1:0]     wdata;
                // Stamped by the request router, not by the master
                logic [ID_W-1:0]       id;
        } ic_req_t;

        // Response, one cycle after the grant
        typedef struct packed {
                logic [DATA_W-1:0] rdata;
                logic [ID_W-1:0]   id;
        } ic_resp_t;

endpackage

// File: source/log_ic_top.sv
/* Logarithmic interconnect top
   Connects N_MASTERS request/grant ports to four word-interleaved SRAM banks */
module log_ic_top
#(
        parameter int N_MASTERS  = 4,
        parameter int BANK_WORDS = 64
)
(
        input  logic                                          clk,
        input  logic                                          rst_n,

        // Request channel per master
        input  logic [N_MASTERS-1:0]                          req_i,
        input  ic_chan_pkg::ic_req_t [N_MASTERS-1:0]          req_data_i,
        output logic [N_MASTERS-1:0]                          gnt_o,

        // Response channel per master, no back-pressure
        output logic [N_MASTERS-1:0]                          r_valid_o,
        output logic [N_MASTERS-1:0][ic_chan_pkg::DATA_W-1:0] r_data_o
);

        // Router to banks
        logic [ic_addr_pkg::N_BANKS-1:0][N_MASTERS-1:0]   bank_req;
        ic_chan_pkg::ic_req_t [N_MASTERS-1:0]             bank_data;
        logic [ic_addr_pkg::N_BANKS-1:0][N_MASTERS-1:0]   bank_gnt;

        // Banks to response router
        logic [ic_addr_pkg::N_BANKS-1:0]                  bank_valid;
        ic_chan_pkg::ic_resp_t [ic_addr_pkg::N_BANKS-1:0] bank_resp;

        //////////////////////////////////////////////////
        // Request side
        //////////////////////////////////////////////////

        req_route #(.N_MASTERS(N_MASTERS)) u_req_route
        (
                .req_i       (req_i),
                .req_data_i  (req_data_i),
                .gnt_o       (gnt_o),
                .bank_req_o  (bank_req),
                .bank_data_o (bank_data),
                .bank_gnt_i  (bank_gnt)
        );

        //////////////////////////////////////////////////
        // Banks
        //////////////////////////////////////////////////

        // All banks see the same payload, strobes differ
        for (genvar b = 0; b < ic_addr_pkg::N_BANKS; b++)
        begin : g_bank
                bank_port
                #(
                        .N_MASTERS  (N_MASTERS),
                        .BANK_WORDS (BANK_WORDS)
                )
                u_bank
                (
                        .clk          (clk),
                        .rst_n        (rst_n),
                        .req_i        (bank_req[b]),
                        .data_i       (bank_data),
                        .gnt_o        (bank_gnt[b]),
                        .resp_valid_o (bank_valid[b]),
                        .resp_o       (bank_resp[b])
                );
        end

        // Response side
        resp_route #(.N_MASTERS(N_MASTERS)) u_resp_route
        (
                .bank_valid_i (bank_valid),
                .bank_resp_i  (bank_resp),
                .r_valid_o    (r_valid_o),
                .r_data_o     (r_data_o)
        );

endmodule

// File: source/req_arb_node.sv
/* Two-input request multiplexer
   Merges two request channels with a toggling round robin priority flag */
module req_arb_node
(
        input  logic                 clk,
        input  logic                 rst_n,

        // Lower input, favoured right after reset
        input  logic                 req0_i,
        input  ic_chan_pkg::ic_req_t data0_i,
        output logic                 gnt0_o,

        // Upper input
        input  logic                 req1_i,
        input  ic_chan_pkg::ic_req_t data1_i,
        output logic                 gnt1_o,

        // Towards the root of the tree
        output logic                 req_o,
        output ic_chan_pkg::ic_req_t data_o,
        input  logic                 gnt_i
);

        // Priority flag, high favours input 1
        logic rr_flag;
        // Mux select
        logic sel;

        // Either side requesting makes this node request
        assign req_o = req0_i | req1_i;

        // Input 1 when input 0 idles, or when both contend and the flag says so
        assign sel = ~req0_i | (rr_flag & req1_i);

        // Grant only the selected side, and only when granted from above
        assign gnt0_o = req0_i & (~req1_i | ~rr_flag) & gnt_i;
        assign gnt1_o = req1_i & (~req0_i | rr_flag) & gnt_i;

        assign data_o = sel ? data1_i : data0_i;

        // Toggle on every forwarded grant
        // under contention the two sides alternate
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        rr_flag <= 1'b0;
                end
                else if (req_o && gnt_i)
                begin
                        rr_flag <= ~rr_flag;
                end
        end

endmodule

// File: source/req_route.sv
/* Request router
   Steers each master's request strobe to its bank and returns that bank's grant */
module req_route
#(
        parameter int N_MASTERS = 4
)
(
        // Master side
        input  logic [N_MASTERS-1:0]                       req_i,
        input  ic_chan_pkg::ic_req_t [N_MASTERS-1:0]       req_data_i,
        output logic [N_MASTERS-1:0]                       gnt_o,

        // Bank side, one strobe row per bank
        output logic [ic_addr_pkg::N_BANKS-1:0][N_MASTERS-1:0] bank_req_o,
        output ic_chan_pkg::ic_req_t [N_MASTERS-1:0]           bank_data_o,
        input  logic [ic_addr_pkg::N_BANKS-1:0][N_MASTERS-1:0] bank_gnt_i
);

        // Bank picked by each master's address
        logic [N_MASTERS-1:0][ic_addr_pkg::BANK_W-1:0] bank_sel;

        //////////////////////////////////////////////////
        // Bank decode and id stamp
        //////////////////////////////////////////////////

        always_comb
        begin
                for (int m = 0; m < N_MASTERS; m++)
                begin
                        bank_sel[m] = req_data_i[m].addr.fields.bank;
                        // Payload goes to every bank, only the strobe is steered
                        bank_data_o[m]    = req_data_i[m];
                        // Port index replaces whatever id the master sent
                        bank_data_o[m].id = ic_chan_pkg::ID_W'(m);
                end
        end

        //////////////////////////////////////////////////
        // Strobe steering and grant return
        //////////////////////////////////////////////////

        always_comb
        begin
                bank_req_o = '0;
                gnt_o      = '0;
                for (int m = 0; m < N_MASTERS; m++)
                begin
                        // Raise the strobe on the selected bank only
                        bank_req_o[bank_sel[m]][m] = req_i[m];
                        // Grant seen by the master comes from that same bank
                        gnt_o[m] = bank_gnt_i[bank_sel[m]][m];
                end
        end

endmodule

// File: source/resp_route.sv
/* Response router
   Returns each bank's registered response to the master named by its id */
module resp_route
#(
        parameter int N_MASTERS = 4
)
(
        // One response per bank per cycle at most
        input  logic [ic_addr_pkg::N_BANKS-1:0]                  bank_valid_i,
        input  ic_chan_pkg::ic_resp_t [ic_addr_pkg::N_BANKS-1:0] bank_resp_i,

        // Master side
        output logic [N_MASTERS-1:0]                             r_valid_o,
        output logic [N_MASTERS-1:0][ic_chan_pkg::DATA_W-1:0]    r_data_o
);

        //////////////////////////////////////////////////
        // Id match per master
        //////////////////////////////////////////////////

        // A master had one grant at most last cycle
        // so at most one bank matches its id
        always_comb
        begin
                r_valid_o = '0;
                r_data_o  = '0;
                for (int m = 0; m < N_MASTERS; m++)
                begin
                        for (int b = 0; b < ic_addr_pkg::N_BANKS; b++)
                        begin
                                if (bank_valid_i[b] &&
                                    bank_resp_i[b].id == ic_chan_pkg::ID_W'(m))
                                begin
                                        r_valid_o[m] = 1'b1;
                                        r_data_o[m]  = bank_resp_i[b].rdata;
                                end
                        end
                end
        end

endmodule

// File: tb.f
source/ic_addr_pkg.sv
source/ic_chan_pkg.sv
source/req_arb_node.sv
source/req_route.sv
source/bank_port.sv
source/resp_route.sv
source/log_ic_top.sv
verif/tb_log_ic.sv

// File: verif/tb_log_ic.sv
/* Logarithmic interconnect testbench
   Random traffic from four masters checked against a banked memory model */
module tb_log_ic;

        localparam int N_M        = 4;
        localparam int BANK_WORDS = 64;
        localparam logic [31:0] SEED = 32'h4900;

        // Transactions per master in each test
        localparam int P_WR_RD    = 16;
        localparam int P_BYTE_EN  = 24;
        localparam int P_CONTEND  = 40;
        localparam int P_INTERLV  = 60;
        localparam int TOTAL_TXN  = N_M * (P_WR_RD + P_BYTE_EN + P_CONTEND + P_INTERLV);
        // Worst case budget per transaction, plus reset and idle cycles
        localparam int WATCHDOG_CYCLES = TOTAL_TXN * N_M * 4 + 20;

        logic                                  clk;
        logic                                  rst_n;
        logic [N_M-1:0]                        req_i;
        ic_chan_pkg::ic_req_t [N_M-1:0]        req_data_i;
        logic [N_M-1:0]                        gnt_o;
        logic [N_M-1:0]                        r_valid_o;
        logic [N_M-1:0][31:0]                  r_data_o;

        // Memory model, one known bit per byte
        logic [31:0] mem_model [ic_addr_pkg::N_BANKS][BANK_WORDS];
        logic [3:0]  known     [ic_addr_pkg::N_BANKS][BANK_WORDS];

        // One pending response slot per master
        logic [N_M-1:0] pend;
        logic [31:0]    exp_data [N_M];
        logic [31:0]    exp_mask [N_M];
        // Transfer seen at the last rising edge
        logic [N_M-1:0] took;
        int             refused  [N_M];

        logic [31:0] rand_state;
        logic [27:0] last_row [N_M];
        logic        uncontested;
        string       test_name;

        log_ic_top
        #(
                .N_MASTERS  (N_M),
                .BANK_WORDS (BANK_WORDS)
        )
        dut0
        (
                .clk        (clk),
                .rst_n      (rst_n),
                .req_i      (req_i),
                .req_data_i (req_data_i),
                .gnt_o      (gnt_o),
                .r_valid_o  (r_valid_o),
                .r_data_o   (r_data_o)
        );

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        //////////////////////////////////////////////////
        // Helpers
        //////////////////////////////////////////////////

        // LCG step
        function automatic logic [31:0] next_rand();
                rand_state = rand_state * 32'd1664525 + 32'd1013904223;
                return rand_state;
        endfunction

        // Expand per-byte known bits to a word mask
        function automatic logic [31:0] byte_mask(input logic [3:0] k);
                logic [31:0] mask;
                for (int j = 0; j < 4; j++)
                begin
                        mask[8*j +: 8] = {8{k[j]}};
                end
                return mask;
        endfunction

        task automatic stop_run();
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped on first failure");
        endtask

        task automatic check_value(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual)
                begin
                        $display("Error %s %s: expected %h actual %h",
                                 test_name, what, expected, actual);
                        stop_run();
                end
        endtask

        // No requests, so nothing may be granted or returned
        task automatic check_idle(input int cycles);
                repeat (cycles)
                begin
                        @(negedge clk);
                        check_value("gnt_o", '0, 32'(gnt_o));
                        check_value("r_valid_o", '0, 32'(r_valid_o));
                end
        endtask

        // Build one request for master m, shaped by the test mode
        task automatic make_request(input int m, input int mode, input int i);
                logic [31:0] rnd;
                logic [31:0] rnd2;
                logic [27:0] row;
                logic [1:0]  bank;
                logic        we;
                logic [3:0]  be;
                rnd  = next_rand();
                rnd2 = next_rand();
                be   = rnd[26:23];
                case (mode)
                1:
                begin
                        // Own bank, write a row then read it back
                        bank = 2'(m);
                        row  = 28'(i / 2);
                        we   = (i % 2 == 0);
                        be   = 4'hF;
                end
                2:
                begin
                        bank = 2'(m);
                        if (i % 2 == 0)
                        begin
                                row         = 28'(rnd[22:20]);
                                last_row[m] = row;
                                we          = 1'b1;
                        end
                        else
                        begin
                                row = last_row[m];
                                we  = 1'b0;
                        end
                end
                3:
                begin
                        // Everyone on bank 2
                        bank = 2'd2;
                        row  = 28'(rnd[22:19]);
                        we   = rnd[27];
                end
                default:
                begin
                        // Full row range, upper bits wrap modulo bank depth
                        bank = rnd[29:28];
                        row  = rnd2[31:4];
                        we   = rnd[27];
                end
                endcase
                req_data_i[m].addr.flat = {row, bank, rnd[17:16]};
                req_data_i[m].we        = we;
                req_data_i[m].be        = be;
                req_data_i[m].wdata     = next_rand();
                // Garbage id, the router must overwrite it
                req_data_i[m].id        = rnd[15:8];
                req_i[m]                = 1'b1;
        endtask

        // Issue count requests per master, holding each until granted
        task automatic run_phase(input int mode, input int count);
                int          left   [N_M];
                int          issued [N_M];
                logic        busy;
                logic [31:0] coin;
                for (int m = 0; m < N_M; m++)
                begin
                        left[m]   = count;
                        issued[m] = 0;
                end
                busy = 1'b1;
                while (busy)
                begin
                        @(negedge clk);
                        busy = 1'b0;
                        for (int m = 0; m < N_M; m++)
                        begin
                                coin = next_rand();
                                if (!req_i[m] || took[m])
                                begin
                                        // Random idle cycles only under contention
                                        if (left[m] > 0 && !(mode == 3 && coin[31:30] == 2'b00))
                                        begin
                                                make_request(m, mode, issued[m]);
                                                left[m]   = left[m] - 1;
                                                issued[m] = issued[m] + 1;
                                        end
                                        else
                                        begin
                                                req_i[m] = 1'b0;
                                        end
                                end
                                if (left[m] > 0 || req_i[m])
                                begin
                                        busy = 1'b1;
                                end
                        end
                end
                // Let the last responses be checked
                @(negedge clk);
        endtask

        //////////////////////////////////////////////////
        // Monitor and memory model
        //////////////////////////////////////////////////

        always @(posedge clk)
        begin : monitor
                logic [31:0] addr;
                int          bank;
                int          idx;
                int          bank_grants [ic_addr_pkg::N_BANKS];
                if (!rst_n)
                begin
                        pend = '0;
                        took = '0;
                        for (int m = 0; m < N_M; m++)
                        begin
                                refused[m] = 0;
                        end
                        for (int b = 0; b < ic_addr_pkg::N_BANKS; b++)
                        begin
                                for (int w = 0; w < BANK_WORDS; w++)
                                begin
                                        known[b][w] = '0;
                                end
                        end
                end
                else
                begin
                        // Responses for last cycle's transfers, exactly one each
                        for (int m = 0; m < N_M; m++)
                        begin
                                check_value($sformatf("r_valid_o[%0d]", m),
                                            32'(pend[m]), 32'(r_valid_o[m]));
                                if (pend[m])
                                begin
                                        check_value($sformatf("r_data_o[%0d]", m),
                                                    exp_data[m] & exp_mask[m],
                                                    r_data_o[m] & exp_mask[m]);
                                end
                                pend[m] = 1'b0;
                        end
                        for (int b = 0; b < ic_addr_pkg::N_BANKS; b++)
                        begin
                                bank_grants[b] = 0;
                        end
                        // Transfers at this edge
                        for (int m = 0; m < N_M; m++)
                        begin
                                if (req_i[m] && gnt_o[m])
                                begin
                                        addr = req_data_i[m].addr.flat;
                                        // Bank in bits 3:2, row above
                                        bank = int'(addr[3:2]);
                                        idx  = int'(addr[31:4]) % BANK_WORDS;
                                        bank_grants[bank] = bank_grants[bank] + 1;
                                        exp_data[m] = mem_model[bank][idx];
                                        exp_mask[m] = byte_mask(known[bank][idx]);
                                        for (int j = 0; j < 4; j++)
                                        begin
                                                if (req_data_i[m].we && req_data_i[m].be[j])
                                                begin
                                                        mem_model[bank][idx][8*j +: 8] =
                                                                req_data_i[m].wdata[8*j +: 8];
                                                        known[bank][idx][j] = 1'b1;
                                                end
                                        end
                                        pend[m]    = 1'b1;
                                        took[m]    = 1'b1;
                                        refused[m] = 0;
                                end
                                else
                                begin
                                        took[m] = 1'b0;
                                        if (req_i[m])
                                        begin
                                                refused[m] = refused[m] + 1;
                                                if (uncontested)
                                                begin
                                                        $display("Master %0d was not granted at once on its own bank in %s",
                                                                 m, test_name);
                                                        stop_run();
                                                end
                                                else if (refused[m] >= N_M)
                                                begin
                                                        $display("Master %0d waited %0d cycles for a grant in %s",
                                                                 m, refused[m], test_name);
                                                        stop_run();
                                                end
                                        end
                                end
                        end
                        // One access per bank per cycle
                        for (int b = 0; b < ic_addr_pkg::N_BANKS; b++)
                        begin
                                if (bank_grants[b] > 1)
                                begin
                                        $display("Bank %0d granted %0d masters in one cycle in %s",
                                                 b, bank_grants[b], test_name);
                                        stop_run();
                                end
                        end
                end
        end

        // Hard limit on run length
        initial
        begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("Watchdog expired after %0d cycles, the run did not finish",
                         WATCHDOG_CYCLES);
                stop_run();
        end

        //////////////////////////////////////////////////
        // Test sequence
        //////////////////////////////////////////////////

        initial
        begin
                rst_n       = 1'b0;
                req_i       = '0;
                req_data_i  = '0;
                rand_state  = SEED;
                uncontested = 1'b0;
                test_name   = "reset";
                for (int m = 0; m < N_M; m++)
                begin
                        last_row[m] = '0;
                end
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                check_idle(4);

                // Own banks only, every request granted at once
                uncontested = 1'b1;
                test_name   = "write_read";
                run_phase(1, P_WR_RD);
                test_name   = "byte_enable";
                run_phase(2, P_BYTE_EN);
                uncontested = 1'b0;

                test_name = "contention";
                run_phase(3, P_CONTEND);
                test_name = "interleave";
                run_phase(4, P_INTERLV);

                $display("TEST PASSED");
                $finish;
        end

endmodule
